// ==== crcahb.f ====
+incdir+design
design/crcahb_pkg.sv
design/host_interface.sv
design/crc_buffer.sv
design/crc_byte_counter.sv
design/crc_control.sv
design/crc_compute.sv
design/crcahb_top.sv
tests/tb_clock.sv
tests/crcahb_tb.sv

// ==== design/crc_buffer.sv ====
// Holds one word only, a write while full is refused until the host stall lets it through
`timescale 1ns/1ps
`default_nettype none
`include "crcahb_macros.svh"

module crc_buffer
	import crcahb_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire crc_cfg_t cfg,
	input  wire  [31:0] bus_wr,
	input  wire  [1:0]  bus_size,
	input  wire         buffer_write_en,
	input  wire         pop,
	output logic        buffer_full,
	output buf_word_t   buf_word
);

	logic accept;

	// Bit reversal inside 8, 16 or 32 bit groups
	// m is the group mask, zero leaves the word as is
	function automatic logic [31:0] reverse_in(input logic [31:0] w, input logic [1:0] mode);
		logic [31:0] r;
		int m;
		case (mode)
			2'b01:   m = 7;
			2'b10:   m = 15;
			2'b11:   m = 31;
			default: m = 0;
		endcase
		for (int i = 0; i < 32; i++)
			r[i] = w[(i & ~m) | (m - (i & m))];
		return r;
	endfunction

	// Same condition as HREADYOUT high for a data write
	assign accept = buffer_write_en && !buffer_full;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			buffer_full <= 1'b0;
		else if (accept)
			buffer_full <= 1'b1;
		else if (pop)
			buffer_full <= 1'b0;
	end

	// Payload
	always_ff @(posedge HCLK)
	begin
		if (accept)
		begin
			buf_word.data.word <= reverse_in(bus_wr, cfg.rev_in);
			buf_word.size      <= bus_size;
		end
	end

	// A refused write is still presented on the next cycle unless pop freed the slot
	assert property (@(posedge HCLK) disable iff (!HRESETn || !`CRCAHB_ASSERT_ON)
		buffer_write_en && buffer_full && !pop |=> buffer_write_en && buffer_full);

endmodule

`default_nettype wire

// ==== design/crc_byte_counter.sv ====
// Counts at most four bytes, load_count must be 1, 2 or 4
`timescale 1ns/1ps
`default_nettype none
`include "crcahb_macros.svh"

module crc_byte_counter (
	input  wire        HCLK,
	input  wire        HRESETn,
	input  wire        load,
	input  wire  [2:0] load_count,
	input  wire        dec,
	output logic       last
);

	// Bytes still to go in the current word
	logic [2:0] count;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count <= 3'd0;
		else if (load)
			count <= load_count;
		else if (dec)
			count <= count - 3'd1;
	end

	// Final byte of the word is on the engine input
	assign last = (count == 3'd1);

	// Sequencer never steps past the end of a word
	assert property (@(posedge HCLK) disable iff (!HRESETn || !`CRCAHB_ASSERT_ON)
		dec |-> count != 3'd0);

endmodule

`default_nettype wire

// ==== design/crc_compute.sv ====
// MSB-first CRC without reflection, one byte per cycle, INIT and POL are masked to the width in use
`timescale 1ns/1ps
`default_nettype none
`include "crcahb_macros.svh"

module crc_compute
	import crcahb_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire crc_cfg_t cfg,
	input  wire  [31:0] bus_wr,
	input  wire         crc_init_en,
	input  wire         crc_poly_en,
	input  wire         crc_idr_en,
	input  wire         byte_valid,
	input  wire  [7:0]  byte_data,
	input  wire         chain_load,
	output logic [31:0] crc_out,
	output logic [31:0] crc_init_out,
	output logic [31:0] crc_poly_out,
	output logic [7:0]  crc_idr_out
);

	logic [31:0] crc_q;
	// Register window for the selected width
	logic [31:0] mask;
	logic [4:0]  top;

	// Eight shift-and-XOR steps, data MSB first into the feedback
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d,
		input logic [31:0] p, input logic [31:0] m, input logic [4:0] t);
		logic [31:0] r;
		logic fb;
		r = c;
		for (int i = 7; i >= 0; i--)
		begin
			fb = r[t] ^ d[i];
			r = (r << 1) & m;
			if (fb)
				r = r ^ (p & m);
		end
		return r;
	endfunction

	// Mirror bits t..0, bits above the window read as zero
	function automatic logic [31:0] reverse_out(input logic [31:0] c, input logic [4:0] t);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < 32; i++)
		begin
			if (i <= int'(t))
				r[i] = c[int'(t) - i];
		end
		return r;
	endfunction

	always_comb
	begin
		case (cfg.poly_size)
			2'b00:   begin mask = 32'hFFFF_FFFF; top = 5'd31; end
			2'b01:   begin mask = 32'h0000_FFFF; top = 5'd15; end
			2'b10:   begin mask = 32'h0000_00FF; top = 5'd7;  end
			default: begin mask = 32'h0000_007F; top = 5'd6;  end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_q        <= `CRC_INIT_RESET;
			crc_init_out <= `CRC_INIT_RESET;
			crc_poly_out <= `CRC_POLY_RESET;
			crc_idr_out  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				crc_init_out <= bus_wr;
			if (crc_poly_en)
				crc_poly_out <= bus_wr;
			if (crc_idr_en)
				crc_idr_out <= bus_wr[7:0];
			// INIT write restarts the CRC directly
			if (crc_init_en)
				crc_q <= bus_wr & mask;
			else if (chain_load)
				crc_q <= crc_init_out & mask;
			else if (byte_valid)
				crc_q <= crc_byte(crc_q, byte_data, crc_poly_out, mask, top);
		end
	end

	// Output reversal across the selected width only
	assign crc_out = cfg.rev_out ? reverse_out(crc_q, top) : crc_q;

endmodule

`default_nettype wire

// ==== design/crc_control.sv ====
// Bytes leave lowest first, a pending chain reset waits for every word written before it
`timescale 1ns/1ps
`default_nettype none

module crc_control
	import crcahb_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire         buffer_full,
	input  wire buf_word_t buf_word,
	input  wire         reset_chain,
	output logic        pop,
	output logic        byte_valid,
	output logic [7:0]  byte_data,
	output logic        chain_load,
	output logic        read_wait,
	output logic        reset_pending
);

	ctrl_state_e state;
	dr_word_u    shift_q;
	logic [1:0]  size_q;
	logic        cnt_load;
	logic [2:0]  load_count;
	logic        last;
	// Buffered word was written before the pending chain reset
	logic        held_word;

	//////////////////////////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////////////////////////

	// Older data drains first, newer data waits for the chain reload
	assign pop        = (state == C_IDLE) && buffer_full && (!reset_pending || held_word);
	assign chain_load = (state == C_IDLE) && reset_pending && !pop;

	assign cnt_load   = (state == C_LOAD);
	assign byte_valid = (state == C_RUN);
	assign byte_data  = shift_q.bytes[0];

	// A pending chain reset also holds off DR reads so the result is settled
	assign read_wait = (state != C_IDLE) || buffer_full || reset_pending;

	always_comb
	begin
		case (size_q)
			2'b00:   load_count = 3'd1;
			2'b01:   load_count = 3'd2;
			default: load_count = 3'd4;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			state <= C_IDLE;
		else
		begin
			case (state)
				C_IDLE:  if (pop) state <= C_LOAD;
				C_LOAD:  state <= C_RUN;
				C_RUN:   if (last) state <= C_IDLE;
				default: state <= C_IDLE;
			endcase
		end
	end

	// Shift word, next byte always in the low lane
	always_ff @(posedge HCLK)
	begin
		if (pop)
		begin
			shift_q <= buf_word.data;
			size_q  <= buf_word.size;
		end
		else if (byte_valid)
			shift_q.word <= shift_q.word >> 8;
	end

	//////////////////////////////////////////////////////////////////////
	// Chain reset bookkeeping
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			reset_pending <= 1'b0;
			held_word     <= 1'b0;
		end
		else
		begin
			if (reset_chain)
				reset_pending <= 1'b1;
			else if (chain_load)
				reset_pending <= 1'b0;
			// Word still in the buffer at the CR write belongs before the reset
			if (reset_chain)
				held_word <= buffer_full && !pop;
			else if (pop)
				held_word <= 1'b0;
		end
	end

	crc_byte_counter u_byte_counter (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.load       (cnt_load),
		.load_count (load_count),
		.dec        (byte_valid),
		.last       (last)
	);

endmodule

`default_nettype wire

// ==== design/crcahb_macros.svh ====
// Register offsets are word offsets taken from HADDR[4:2] and the assertion switch is a 1-bit constant
`ifndef CRCAHB_MACROS_SVH
`define CRCAHB_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////

// Data register, written with input data and read for the result
`define CRC_DR_OFS   3'h0
// Independent data register, 8 bits of scratch storage
`define CRC_IDR_OFS  3'h1
// Control register with the chain reset in bit 0
`define CRC_CR_OFS   3'h2
// Initial CRC value
`define CRC_INIT_OFS 3'h4
// Generator polynomial
`define CRC_POL_OFS  3'h5

// Reset values
`define CRC_INIT_RESET 32'hFFFF_FFFF
`define CRC_POLY_RESET 32'h04C1_1DB7

// Set to 1'b0 to mute every concurrent assertion in the RTL
`define CRCAHB_ASSERT_ON 1'b1

`endif

// ==== design/crcahb_pkg.sv ====
// Shared types only, the control register layout here must match the host_interface read mux
`default_nettype none

package crcahb_pkg;

	// Decoded control register, bits 7:3 of CR
	// poly_size 00 = 32 bits, 01 = 16 bits, 10 = 8 bits, 11 = 7 bits
	// rev_in 00 = none, 01 = per byte, 10 = per halfword, 11 = per word
	typedef struct packed {
		logic [1:0] poly_size;
		logic [1:0] rev_in;
		logic       rev_out;
	} crc_cfg_t;

	// One data word
	// The buffer keeps it whole and the engine walks it byte by byte
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} dr_word_u;

	// Buffered data write
	// Size follows HSIZE with 00 byte, 01 halfword, 10 word
	typedef struct packed {
		dr_word_u   data;
		logic [1:0] size;
	} buf_word_t;

	// Engine sequencer states
	typedef enum logic [1:0] {
		C_IDLE = 2'd0,
		C_LOAD = 2'd1,
		C_RUN  = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/crcahb_top.sv ====
// AHB-Lite slave port only, HADDR[4:2] selects the register and HRESP is always OKAY
`timescale 1ns/1ps
`default_nettype none

module crcahb_top
	import crcahb_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire         HSElx,
	input  wire  [31:0] HADDR,
	input  wire  [1:0]  HTRANS,
	input  wire  [2:0]  HSIZE,
	input  wire         HWRITE,
	input  wire         HREADY,
	input  wire  [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	// Host side
	logic [31:0] bus_wr;
	logic [1:0]  bus_size;
	crc_cfg_t    cfg;
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        reset_chain;

	// Buffer and sequencer
	logic        buffer_full;
	buf_word_t   buf_word;
	logic        pop;
	logic        byte_valid;
	logic [7:0]  byte_data;
	logic        chain_load;
	logic        read_wait;
	logic        reset_pending;

	// Register read back
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;

	host_interface u_host_interface (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HREADY          (HREADY),
		.HWDATA          (HWDATA),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.cfg             (cfg),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain)
	);

	crc_buffer u_crc_buffer (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.cfg             (cfg),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.pop             (pop),
		.buffer_full     (buffer_full),
		.buf_word        (buf_word)
	);

	crc_control u_crc_control (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.buffer_full   (buffer_full),
		.buf_word      (buf_word),
		.reset_chain   (reset_chain),
		.pop           (pop),
		.byte_valid    (byte_valid),
		.byte_data     (byte_data),
		.chain_load    (chain_load),
		.read_wait     (read_wait),
		.reset_pending (reset_pending)
	);

	crc_compute u_crc_compute (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.cfg          (cfg),
		.bus_wr       (bus_wr),
		.crc_init_en  (crc_init_en),
		.crc_poly_en  (crc_poly_en),
		.crc_idr_en   (crc_idr_en),
		.byte_valid   (byte_valid),
		.byte_data    (byte_data),
		.chain_load   (chain_load),
		.crc_out      (crc_out),
		.crc_init_out (crc_init_out),
		.crc_poly_out (crc_poly_out),
		.crc_idr_out  (crc_idr_out)
	);

endmodule

`default_nettype wire

// ==== design/host_interface.sv ====
// Acts only on NONSEQ transfers and never answers ERROR, write data must sit in the low HWDATA lanes
`timescale 1ns/1ps
`default_nettype none
`include "crcahb_macros.svh"

module host_interface
	import crcahb_pkg::*;
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire         HSElx,
	input  wire  [31:0] HADDR,
	input  wire  [1:0]  HTRANS,
	input  wire  [2:0]  HSIZE,
	input  wire         HWRITE,
	input  wire         HREADY,
	input  wire  [31:0] HWDATA,
	input  wire  [31:0] crc_out,
	input  wire  [31:0] crc_init_out,
	input  wire  [31:0] crc_poly_out,
	input  wire  [7:0]  crc_idr_out,
	input  wire         buffer_full,
	input  wire         reset_pending,
	input  wire         read_wait,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	output logic [31:0] bus_wr,
	output logic [1:0]  bus_size,
	output crc_cfg_t    cfg,
	output logic        buffer_write_en,
	output logic        crc_init_en,
	output logic        crc_idr_en,
	output logic        crc_poly_en,
	output logic        reset_chain
);

	localparam logic [1:0] NONSEQ = 2'b10;

	// Address phase pipeline
	logic       act_pp;
	logic       hwrite_pp;
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;

	logic sample_bus;
	logic write_en;
	logic read_en;
	logic cr_en;
	logic dr_read;
	logic any_en;

	//////////////////////////////////////////////////////////////////////
	// Address phase capture
	//////////////////////////////////////////////////////////////////////

	// Bus is sampled only when the current data phase completes
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			act_pp    <= 1'b0;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			// Selected NONSEQ transfer, IDLE SEQ and BUSY are dropped here
			act_pp    <= HSElx && (HTRANS == NONSEQ);
			hwrite_pp <= HWRITE;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Register decode in the data phase
	//////////////////////////////////////////////////////////////////////

	assign write_en = act_pp && hwrite_pp;
	assign read_en  = act_pp && !hwrite_pp;

	assign buffer_write_en = write_en && (haddr_pp == `CRC_DR_OFS);
	assign crc_idr_en      = write_en && (haddr_pp == `CRC_IDR_OFS);
	assign cr_en           = write_en && (haddr_pp == `CRC_CR_OFS);
	assign crc_init_en     = write_en && (haddr_pp == `CRC_INIT_OFS);
	assign crc_poly_en     = write_en && (haddr_pp == `CRC_POL_OFS);
	assign dr_read         = read_en && (haddr_pp == `CRC_DR_OFS);

	assign any_en = buffer_write_en || crc_idr_en || cr_en || crc_init_en || crc_poly_en;

	// Write data goes out unregistered, it is valid in the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Bit 0 of a CR write is a self-clearing chain reset
	assign reset_chain = cr_en && HWDATA[0];

	// Wait states
	// Data write into a full buffer
	// Data read while work is pending
	// INIT write while a chain reset is pending
	assign HREADYOUT = !((buffer_write_en && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (crc_init_en && reset_pending));

	assign HRESP = 1'b0;

	// Control register keeps bits 7:3 only
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg <= '0;
		else if (cr_en)
		begin
			cfg.poly_size <= HWDATA[4:3];
			cfg.rev_in    <= HWDATA[6:5];
			cfg.rev_out   <= HWDATA[7];
		end
	end

	// Read data mux on the pipelined offset
	always_comb
	begin
		case (haddr_pp)
			`CRC_DR_OFS:   HRDATA = crc_out;
			`CRC_IDR_OFS:  HRDATA = {24'h0, crc_idr_out};
			`CRC_CR_OFS:   HRDATA = {24'h0, cfg.rev_out, cfg.rev_in, cfg.poly_size, 3'h0};
			`CRC_INIT_OFS: HRDATA = crc_init_out;
			`CRC_POL_OFS:  HRDATA = crc_poly_out;
			default:       HRDATA = 32'h0;
		endcase
	end

	// A DR read completes only once every earlier write has reached the CRC
	assert property (@(posedge HCLK) disable iff (!HRESETn || !`CRCAHB_ASSERT_ON)
		dr_read && HREADYOUT |-> !buffer_full && !reset_pending);

	// Every write enable traces back to a sampled, selected NONSEQ write or a held one
	assert property (@(posedge HCLK) disable iff (!HRESETn || !`CRCAHB_ASSERT_ON)
		any_en |-> $past(sample_bus && HSElx && HWRITE && (HTRANS == NONSEQ)) ||
		           $past(any_en && !sample_bus));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module crcahb_tb -f crcahb.f &&
./obj_dir/Vcrcahb_tb | awk '{ print } /Simulation PASSED/ { ok = 1 } END { exit !ok }' &&
echo "run_sim: testbench passed" ||
{ echo "run_sim: testbench failed"; exit 1; }

// ==== tests/crcahb_tb.sv ====
// HREADY is tied high as on a single-slave bus, CR POL and INIT change only while no data is in flight
`timescale 1ns/1ps
`default_nettype none
`include "crcahb_macros.svh"

module crcahb_tb
	import crcahb_pkg::*;
();

	localparam logic [1:0]  HTRANS_IDLE   = 2'b00;
	localparam logic [1:0]  HTRANS_NONSEQ = 2'b10;
	localparam logic [31:0] CRC_BASE      = 32'h4002_3000;
	// Longest stall is a few words plus a chain reload
	localparam int          WAIT_LIMIT    = 64;

	wire         HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic        HREADY;
	logic [31:0] HWDATA;
	wire  [31:0] HRDATA;
	wire         HREADYOUT;
	wire         HRESP;

	// Pending transfer list, run as one pipelined burst
	logic        xf_sel[$];
	logic [1:0]  xf_trans[$];
	logic        xf_write[$];
	logic [2:0]  xf_ofs[$];
	logic [1:0]  xf_size[$];
	logic [31:0] xf_wdata[$];

	// Register and CRC model
	logic [7:0]  m_cr;
	logic [31:0] m_init;
	logic [31:0] m_poly;
	logic [31:0] m_crc;
	logic [7:0]  m_idr;

	integer      seed;
	int          k;
	int          ri;
	int          ro;
	logic [31:0] r;

	tb_clock i_clock (
		.HCLK (HCLK)
	);

	crcahb_top i_dut (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HREADY    (HREADY),
		.HWDATA    (HWDATA),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// CR bits 4:3 pick 32, 16, 8 or 7 bits
	function automatic int crc_width(input logic [7:0] cr);
		case (cr[4:3])
			2'b00:   return 32;
			2'b01:   return 16;
			2'b10:   return 8;
			default: return 7;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	// Bit order flipped inside every group of g bits
	function automatic logic [31:0] mirror_groups(input logic [31:0] v, input int g);
		logic [31:0] m;
		int          i;
		int          base;
		m = v;
		for (i = 0; i < 32; i++)
		begin
			base = (i / g) * g;
			m[i] = v[base + g - 1 - (i % g)];
		end
		return m;
	endfunction

	// Low w bits flipped, upper bits cleared
	function automatic logic [31:0] mirror_low(input logic [31:0] v, input int w);
		logic [31:0] m;
		int          i;
		m = 32'h0;
		for (i = 0; i < w; i++)
			m[w - 1 - i] = v[i];
		return m;
	endfunction

	// One byte, MSB first, into a w-bit register with no reflection
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d,
		input logic [31:0] p, input int w);
		logic [31:0] s;
		logic        msb;
		int          b;
		s = c;
		for (b = 7; b >= 0; b--)
		begin
			msb = s[w - 1];
			s = (s << 1) & width_mask(w);
			if (msb ^ d[b])
				s = s ^ (p & width_mask(w));
		end
		return s;
	endfunction

	// Applies one completed write to the model
	task automatic model_write(input logic [2:0] ofs, input logic [1:0] size,
		input logic [31:0] wdata);
		logic [31:0] word;
		int          g;
		int          n;
		int          j;
		case (ofs)
			`CRC_DR_OFS:
			begin
				// Input reversal group is 8, 16 or 32 bits
				g = (m_cr[6:5] == 2'b00) ? 1 : (4 << m_cr[6:5]);
				word = mirror_groups(wdata, g);
				n = (size == 2'b00) ? 1 : ((size == 2'b01) ? 2 : 4);
				for (j = 0; j < n; j++)
					m_crc = crc_step(m_crc, word[8 * j +: 8], m_poly, crc_width(m_cr));
			end
			`CRC_IDR_OFS:
				m_idr = wdata[7:0];
			`CRC_CR_OFS:
			begin
				m_cr = wdata[7:0] & 8'hF8;
				// Chain reset, reload INIT under the new width
				if (wdata[0])
					m_crc = m_init & width_mask(crc_width(m_cr));
			end
			`CRC_INIT_OFS:
			begin
				m_init = wdata;
				m_crc = wdata & width_mask(crc_width(m_cr));
			end
			`CRC_POL_OFS:
				m_poly = wdata;
			default: ;
		endcase
	endtask

	function automatic logic [31:0] expected_read(input logic [2:0] ofs);
		case (ofs)
			`CRC_DR_OFS:   return m_cr[7] ? mirror_low(m_crc, crc_width(m_cr)) : m_crc;
			`CRC_IDR_OFS:  return {24'h0, m_idr};
			`CRC_CR_OFS:   return {24'h0, m_cr};
			`CRC_INIT_OFS: return m_init;
			`CRC_POL_OFS:  return m_poly;
			default:       return 32'h0;
		endcase
	endfunction

	function automatic string reg_name(input logic [2:0] ofs);
		case (ofs)
			`CRC_DR_OFS:   return "DR";
			`CRC_IDR_OFS:  return "IDR";
			`CRC_CR_OFS:   return "CR";
			`CRC_INIT_OFS: return "INIT";
			`CRC_POL_OFS:  return "POL";
			default:       return "unmapped";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run(input string why);
		$display("Error: %s", why);
		$display("Simulation FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run("a DUT output differed from the model");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus master
	//////////////////////////////////////////////////////////////////////

	task automatic queue_xfer(input logic sel, input logic [1:0] trans, input logic write,
		input logic [2:0] ofs, input logic [1:0] size, input logic [31:0] wdata);
		xf_sel.push_back(sel);
		xf_trans.push_back(trans);
		xf_write.push_back(write);
		xf_ofs.push_back(ofs);
		xf_size.push_back(size);
		xf_wdata.push_back(wdata);
	endtask

	task automatic queue_write(input logic [2:0] ofs, input logic [1:0] size,
		input logic [31:0] wdata);
		queue_xfer(1'b1, HTRANS_NONSEQ, 1'b1, ofs, size, wdata);
	endtask

	task automatic queue_read(input logic [2:0] ofs);
		queue_xfer(1'b1, HTRANS_NONSEQ, 1'b0, ofs, 2'b10, next_random());
	endtask

	task automatic queue_read_all();
		queue_read(`CRC_CR_OFS);
		queue_read(`CRC_POL_OFS);
		queue_read(`CRC_INIT_OFS);
		queue_read(`CRC_IDR_OFS);
		queue_read(`CRC_DR_OFS);
	endtask

	// Data writes of random size, mostly words
	task automatic queue_data(input int count);
		logic [31:0] v;
		int          j;
		for (j = 0; j < count; j++)
		begin
			v = next_random();
			queue_write(`CRC_DR_OFS, (v[1:0] == 2'b11) ? 2'b10 : v[1:0], next_random());
		end
	endtask

	// CR first, then random POL and INIT
	task automatic queue_config(input logic [7:0] cr);
		queue_write(`CRC_CR_OFS, 2'b10, {24'h0, cr});
		queue_write(`CRC_POL_OFS, 2'b10, next_random());
		queue_write(`CRC_INIT_OFS, 2'b10, next_random());
	endtask

	// Write the DUT must ignore, once unselected and once as IDLE
	task automatic queue_ignored(input logic [2:0] ofs);
		queue_xfer(1'b0, HTRANS_NONSEQ, 1'b1, ofs, 2'b10, next_random());
		queue_xfer(1'b1, HTRANS_IDLE, 1'b1, ofs, 2'b10, next_random());
	endtask

	task automatic drive_address(input int i);
		HSElx  = xf_sel[i];
		HTRANS = xf_trans[i];
		HWRITE = xf_write[i];
		HSIZE  = {1'b0, xf_size[i]};
		HADDR  = CRC_BASE | {27'h0, xf_ofs[i], 2'b00};
	endtask

	task automatic drive_idle();
		HSElx  = 1'b0;
		HTRANS = HTRANS_IDLE;
		HWRITE = 1'b0;
		HSIZE  = 3'b010;
		HADDR  = CRC_BASE;
	endtask

	// Completed data phase, model update or read check
	task automatic finish_transfer(input int i);
		if (xf_sel[i] && (xf_trans[i] == HTRANS_NONSEQ))
		begin
			if (xf_write[i])
				model_write(xf_ofs[i], xf_size[i], xf_wdata[i]);
			else
				check_value({"HRDATA(", reg_name(xf_ofs[i]), ")"}, HRDATA,
					expected_read(xf_ofs[i]));
		end
	endtask

	// Address of transfer d+1 overlaps the data phase of transfer d
	task automatic run_burst();
		int          n;
		int          d;
		int          guard;
		ctrl_state_e st;
		n = xf_write.size();
		@(negedge HCLK);
		// Bus was idle, so the first address phase is sampled
		check_value("HREADYOUT", {31'h0, HREADYOUT}, 32'h1);
		drive_address(0);
		for (d = 0; d < n; d++)
		begin
			@(negedge HCLK);
			HWDATA = xf_wdata[d];
			if (d + 1 < n)
				drive_address(d + 1);
			else
				drive_idle();
			guard = 0;
			// Wait states, drives held
			while (!HREADYOUT)
			begin
				check_value("HRESP", {31'h0, HRESP}, 32'h0);
				guard++;
				if (guard > WAIT_LIMIT)
				begin
					st = i_dut.u_crc_control.state;
					$display("HREADYOUT low for %0d cycles, sequencer in %s", guard, st.name());
					stop_run("timeout while waiting for HREADYOUT");
				end
				@(negedge HCLK);
			end
			check_value("HRESP", {31'h0, HRESP}, 32'h0);
			finish_transfer(d);
		end
		xf_sel.delete();
		xf_trans.delete();
		xf_write.delete();
		xf_ofs.delete();
		xf_size.delete();
		xf_wdata.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed      = 32'hef89;
		HRESETn   = 1'b0;
		HSElx     = 1'b0;
		HADDR     = 32'h0;
		HTRANS    = HTRANS_IDLE;
		HSIZE     = 3'b010;
		HWRITE    = 1'b0;
		HREADY    = 1'b1;
		HWDATA    = 32'h0;
		m_cr      = 8'h00;
		m_init    = `CRC_INIT_RESET;
		m_poly    = `CRC_POLY_RESET;
		m_crc     = `CRC_INIT_RESET;
		m_idr     = 8'h00;
		repeat (2) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;

		// Reset values
		queue_read_all();
		run_burst();

		// Random register writes and read back, CR bit 0 may fire a chain reset
		for (k = 0; k < 4; k++)
		begin
			queue_write(`CRC_CR_OFS, 2'b10, next_random());
			queue_write(`CRC_POL_OFS, 2'b10, next_random());
			queue_write(`CRC_INIT_OFS, 2'b10, next_random());
			queue_write(`CRC_IDR_OFS, 2'b10, next_random());
			queue_read_all();
			run_burst();
		end

		// Every width, no reversal
		for (k = 0; k < 4; k++)
		begin
			queue_config({1'b0, 2'b00, k[1:0], 3'b000});
			queue_data(6 + k);
			queue_read(`CRC_DR_OFS);
			run_burst();
		end

		// Input reversal modes against output reversal, random width
		for (ri = 0; ri < 4; ri++)
		begin
			for (ro = 0; ro < 2; ro++)
			begin
				r = next_random();
				queue_config({ro[0], ri[1:0], r[1:0], 3'b000});
				queue_data(5);
				queue_read(`CRC_DR_OFS);
				run_burst();
			end
		end

		// Chain reset mid-stream, last round follows it with an INIT write that must stall
		for (k = 0; k < 3; k++)
		begin
			r = next_random();
			queue_config(r[7:0] & 8'hF8);
			queue_data(3);
			queue_write(`CRC_CR_OFS, 2'b10, {24'h0, r[7:3], 3'b001});
			if (k == 2)
				queue_write(`CRC_INIT_OFS, 2'b10, next_random());
			queue_data(3);
			queue_read(`CRC_DR_OFS);
			run_burst();
		end

		// Back-to-back words, then bytes, each with a read right behind
		r = next_random();
		queue_config(r[7:0] & 8'hF8);
		for (k = 0; k < 8; k++)
			queue_write(`CRC_DR_OFS, 2'b10, next_random());
		queue_read(`CRC_DR_OFS);
		for (k = 0; k < 8; k++)
			queue_write(`CRC_DR_OFS, 2'b00, next_random());
		queue_read(`CRC_DR_OFS);
		run_burst();

		// Ignored transfers leave every register as it was
		queue_ignored(`CRC_DR_OFS);
		queue_ignored(`CRC_IDR_OFS);
		queue_ignored(`CRC_CR_OFS);
		queue_ignored(`CRC_INIT_OFS);
		queue_ignored(`CRC_POL_OFS);
		queue_read_all();
		run_burst();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Free-running clock from time zero with a 4 ns period, first rising edge at 2 ns
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic HCLK
);

	// Half period of 2 ns
	initial
	begin
		HCLK = 1'b0;
		forever
			#2 HCLK = ~HCLK;
	end

endmodule

`default_nettype wire
